/* hdl/alu_frame_assembler.sv */
`timescale 1ns/1ps

module alu_frame_assembler (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_valid,
    input  uart_alu_pkg::uart_byte_t   i_byte,
    output logic                       o_valid,
    output uart_alu_pkg::alu_request_t o_request
);

    localparam logic [1:0] BYTE_A  = 2'd0;
    localparam logic [1:0] BYTE_B  = 2'd1;
    localparam logic [1:0] BYTE_OP = 2'd2;

    logic [1:0]               byte_index;
    uart_alu_pkg::uart_byte_t operand_a;
    uart_alu_pkg::uart_byte_t operand_b;
    logic                     last_byte;

    assign last_byte = i_valid && (byte_index == BYTE_OP);

    // Byte order is operand A, operand B, then opcode.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_index <= BYTE_A;
            o_valid    <= 1'b0;
        end else begin
            o_valid <= last_byte;
            if (i_valid) begin
                case (byte_index)
                    BYTE_A:  byte_index <= BYTE_B;
                    BYTE_B:  byte_index <= BYTE_OP;
                    default: byte_index <= BYTE_A;
                endcase
            end
        end
    end

    // Operand and request storage.
    always_ff @(posedge i_clock) begin
        if (i_valid && (byte_index == BYTE_A)) begin
            operand_a <= i_byte;
        end
        if (i_valid && (byte_index == BYTE_B)) begin
            operand_b <= i_byte;
        end
        if (last_byte) begin
            o_request.operand_a <= operand_a;
            o_request.operand_b <= operand_b;
            o_request.opcode    <= i_byte[uart_alu_pkg::OPCODE_WIDTH-1:0];
        end
    end

endmodule

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_valid,
    input  uart_alu_pkg::alu_request_t i_request,
    output logic                       o_valid,
    output uart_alu_pkg::uart_byte_t   o_result
);

    uart_alu_pkg::uart_byte_t                   operand_a;
    uart_alu_pkg::uart_byte_t                   operand_b;
    uart_alu_pkg::uart_byte_t                   result;
    logic [$clog2(uart_alu_pkg::DATA_WIDTH)-1:0] shift_amount;

    assign operand_a    = i_request.operand_a;
    assign operand_b    = i_request.operand_b;
    assign shift_amount = operand_b[$clog2(uart_alu_pkg::DATA_WIDTH)-1:0];

    // Sum and difference wrap modulo 256.
    always_comb begin
        case (i_request.opcode)
            uart_alu_pkg::ADD: result = operand_a + operand_b;
            uart_alu_pkg::SUB: result = operand_a - operand_b;
            uart_alu_pkg::AND: result = operand_a & operand_b;
            uart_alu_pkg::OR:  result = operand_a | operand_b;
            uart_alu_pkg::XOR: result = operand_a ^ operand_b;
            uart_alu_pkg::NOR: result = ~(operand_a | operand_b);
            uart_alu_pkg::SRL: result = operand_a >> shift_amount;
            uart_alu_pkg::SRA: result = $signed(operand_a) >>> shift_amount;
            default:           result = '0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_result <= result;
        end
    end

endmodule

/* hdl/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int CLOCKS_PER_TICK = 27
) (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    localparam int COUNT_WIDTH = (CLOCKS_PER_TICK > 1) ? $clog2(CLOCKS_PER_TICK) : 1;
    localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLOCKS_PER_TICK - 1);

    logic [COUNT_WIDTH-1:0] count;

    // Counter wraps and pulses the tick once per period.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == LAST_COUNT) begin
            count  <= '0;
            o_tick <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

/* hdl/uart_alu_pkg.sv */
package uart_alu_pkg;

    //////////////////////////////////////////////////
    // Word sizes and bit timing.
    //////////////////////////////////////////////////

    // Serial data word, also the ALU operand width.
    localparam int DATA_WIDTH = 8;

    // Opcode sits in the low bits of the third byte.
    localparam int OPCODE_WIDTH = 6;

    // Oversampling ticks per bit period.
    localparam int OVERSAMPLE = 16;

    typedef logic [DATA_WIDTH-1:0] uart_byte_t;

    //////////////////////////////////////////////////
    // ALU operations.
    //////////////////////////////////////////////////

    typedef enum logic [OPCODE_WIDTH-1:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        XOR = 6'h26,
        NOR = 6'h27,
        SRL = 6'h02,
        SRA = 6'h03
    } alu_op_e;

    // One complete request, built from three received bytes.
    typedef struct packed {
        uart_byte_t              operand_a;
        uart_byte_t              operand_b;
        logic [OPCODE_WIDTH-1:0] opcode;
    } alu_request_t;

endpackage

/* hdl/uart_alu_top.sv */
`timescale 1ns/1ps

module uart_alu_top #(
    parameter int CLOCKS_PER_TICK = 27,
    parameter int STOP_BITS       = 2
) (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx,
    output logic o_tx_done,
    output logic o_frame_error
);

    logic                       tick;
    logic                       rx_valid;
    uart_alu_pkg::uart_byte_t   rx_byte;
    logic                       req_valid;
    uart_alu_pkg::alu_request_t req;
    logic                       res_valid;
    uart_alu_pkg::uart_byte_t   res_byte;

    // Shared oversampling tick for both serial directions.
    baud_tick_gen #(
        .CLOCKS_PER_TICK(CLOCKS_PER_TICK)
    ) u_baud_tick_gen (
        .i_clock(i_clock),
        .i_reset(i_reset),
        .o_tick (tick)
    );

    uart_rx #(
        .STOP_BITS(STOP_BITS)
    ) u_uart_rx (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_tick       (tick),
        .i_rx         (i_rx),
        .o_valid      (rx_valid),
        .o_byte       (rx_byte),
        .o_frame_error(o_frame_error)
    );

    alu_frame_assembler u_alu_frame_assembler (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (rx_valid),
        .i_byte   (rx_byte),
        .o_valid  (req_valid),
        .o_request(req)
    );

    alu_stage u_alu_stage (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (req_valid),
        .i_request(req),
        .o_valid  (res_valid),
        .o_result (res_byte)
    );

    uart_tx #(
        .STOP_BITS(STOP_BITS)
    ) u_uart_tx (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_tick   (tick),
        .i_valid  (res_valid),
        .i_data   (res_byte),
        .o_tx     (o_tx),
        .o_tx_done(o_tx_done)
    );

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int STOP_BITS = 2
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_tick,
    input  logic                     i_rx,
    output logic                     o_valid,
    output uart_alu_pkg::uart_byte_t o_byte,
    output logic                     o_frame_error
);

    localparam logic [3:0] IDLE  = 4'b0001;
    localparam logic [3:0] START = 4'b0010;
    localparam logic [3:0] DATA  = 4'b0100;
    localparam logic [3:0] STOP  = 4'b1000;

    localparam int TICK_WIDTH = $clog2(uart_alu_pkg::OVERSAMPLE);
    localparam int BIT_WIDTH  = $clog2(uart_alu_pkg::DATA_WIDTH);
    localparam int STOP_WIDTH = (STOP_BITS > 1) ? $clog2(STOP_BITS) : 1;

    localparam logic [TICK_WIDTH-1:0] MID_TICK  = TICK_WIDTH'(uart_alu_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TICK_WIDTH-1:0] LAST_TICK = TICK_WIDTH'(uart_alu_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_WIDTH-1:0]  LAST_BIT  = BIT_WIDTH'(uart_alu_pkg::DATA_WIDTH - 1);
    localparam logic [STOP_WIDTH-1:0] LAST_STOP = STOP_WIDTH'(STOP_BITS - 1);

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
    logic [3:0]               state;
    logic [TICK_WIDTH-1:0]    tick_count;
    logic [BIT_WIDTH-1:0]     bit_count;
    logic [STOP_WIDTH-1:0]    stop_count;
    uart_alu_pkg::uart_byte_t shift_reg;
    logic                     bit_sample;
    logic                     stop_sample;

    // Two flop synchronizer, third flop for edge detect.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Sample points, 16 ticks apart after the start check.
    assign bit_sample    = i_tick && (tick_count == LAST_TICK);
    assign stop_sample   = (state == STOP) && bit_sample;
    assign o_valid       = stop_sample && rx_sync && (stop_count == LAST_STOP);
    assign o_frame_error = stop_sample && !rx_sync;
    assign o_byte        = shift_reg;

    //////////////////////////////////////////////////
    // Frame state machine.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            stop_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    tick_count <= '0;
                    bit_count  <= '0;
                    stop_count <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (i_tick) begin
                        if (tick_count == MID_TICK) begin
                            // A high line at mid-bit was only a glitch.
                            tick_count <= '0;
                            state      <= rx_sync ? IDLE : DATA;
                        end else begin
                            tick_count <= tick_count + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (i_tick) begin
                        tick_count <= bit_sample ? '0 : tick_count + 1'b1;
                    end
                    if (bit_sample) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == LAST_BIT) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (i_tick) begin
                        tick_count <= bit_sample ? '0 : tick_count + 1'b1;
                    end
                    if (bit_sample) begin
                        stop_count <= stop_count + 1'b1;
                        if (!rx_sync || (stop_count == LAST_STOP)) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data bits arrive MSB first.
    always_ff @(posedge i_clock) begin
        if ((state == DATA) && bit_sample) begin
            shift_reg <= {shift_reg[uart_alu_pkg::DATA_WIDTH-2:0], rx_sync};
        end
    end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int STOP_BITS = 2
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_tick,
    input  logic                     i_valid,
    input  uart_alu_pkg::uart_byte_t i_data,
    output logic                     o_tx,
    output logic                     o_tx_done
);

    localparam logic [3:0] WAIT  = 4'b0001;
    localparam logic [3:0] START = 4'b0010;
    localparam logic [3:0] DATA  = 4'b0100;
    localparam logic [3:0] STOP  = 4'b1000;

    localparam int TICK_WIDTH = $clog2(uart_alu_pkg::OVERSAMPLE);
    localparam int BIT_WIDTH  = $clog2(uart_alu_pkg::DATA_WIDTH);
    localparam int STOP_WIDTH = (STOP_BITS > 1) ? $clog2(STOP_BITS) : 1;

    localparam logic [TICK_WIDTH-1:0] LAST_TICK = TICK_WIDTH'(uart_alu_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_WIDTH-1:0]  LAST_BIT  = BIT_WIDTH'(uart_alu_pkg::DATA_WIDTH - 1);
    localparam logic [STOP_WIDTH-1:0] LAST_STOP = STOP_WIDTH'(STOP_BITS - 1);

    logic [3:0]               state;
    logic                     pending;
    logic [TICK_WIDTH-1:0]    tick_count;
    logic [BIT_WIDTH-1:0]     bit_count;
    logic [STOP_WIDTH-1:0]    stop_count;
    uart_alu_pkg::uart_byte_t shift_reg;
    logic                     load;
    logic                     bit_end;

    // New bytes are only accepted while idle with nothing queued.
    assign load    = (state == WAIT) && !pending && i_valid;
    assign bit_end = i_tick && (tick_count == LAST_TICK);

    //////////////////////////////////////////////////
    // Frame state machine.
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= WAIT;
            pending    <= 1'b0;
            tick_count <= '0;
            bit_count  <= '0;
            stop_count <= '0;
        end else begin
            if ((state != WAIT) && i_tick) begin
                tick_count <= bit_end ? '0 : tick_count + 1'b1;
            end
            case (state)
                WAIT: begin
                    tick_count <= '0;
                    bit_count  <= '0;
                    stop_count <= '0;
                    if (load) begin
                        pending <= 1'b1;
                    end else if (pending && i_tick) begin
                        // Frame starts on a tick boundary.
                        pending <= 1'b0;
                        state   <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == LAST_BIT) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        stop_count <= stop_count + 1'b1;
                        if (stop_count == LAST_STOP) begin
                            state <= WAIT;
                        end
                    end
                end
                default: state <= WAIT;
            endcase
        end
    end

    // MSB leaves first.
    always_ff @(posedge i_clock) begin
        if (load) begin
            shift_reg <= i_data;
        end else if ((state == DATA) && bit_end) begin
            shift_reg <= {shift_reg[uart_alu_pkg::DATA_WIDTH-2:0], 1'b0};
        end
    end

    always_comb begin
        case (state)
            START:   o_tx = 1'b0;
            DATA:    o_tx = shift_reg[uart_alu_pkg::DATA_WIDTH-1];
            default: o_tx = 1'b1;
        endcase
    end

    assign o_tx_done = (state == WAIT);

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the UART ALU testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module uart_alu_tb \
    -f uart_alu_top.f \
    -o Vuart_alu_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vuart_alu_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

exit 0

/* uart_alu_top.f */
hdl/uart_alu_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/alu_frame_assembler.sv
hdl/alu_stage.sv
hdl/uart_tx.sv
hdl/uart_alu_top.sv
verif/uart_alu_tb.sv

/* verif/uart_alu_tb.sv */
`timescale 1ns/1ps

module uart_alu_tb;

    localparam int CLOCKS_PER_TICK = 4;
    localparam int STOP_BITS       = 2;
    localparam int BIT_CYCLES      = CLOCKS_PER_TICK * uart_alu_pkg::OVERSAMPLE;
    localparam int REPLY_TIMEOUT   = 16 * BIT_CYCLES;
    localparam int FRAME_TIMEOUT   = 12 * BIT_CYCLES;
    localparam int IDLE_CYCLES     = 4 * BIT_CYCLES;
    localparam int ROW_COUNT       = 11;

    // One stimulus row with its expected reply.
    typedef struct packed {
        logic [7:0] operand_a;
        logic [7:0] operand_b;
        logic [7:0] opcode;
        logic [7:0] expected;
        logic       bad_stop;
    } test_row_t;

    logic      i_clock;
    logic      i_reset;
    logic      i_rx;
    logic      o_tx;
    logic      o_tx_done;
    logic      o_frame_error;
    test_row_t rows [ROW_COUNT];

    uart_alu_top #(
        .CLOCKS_PER_TICK(CLOCKS_PER_TICK),
        .STOP_BITS      (STOP_BITS)
    ) DUT (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx         (i_rx),
        .o_tx         (o_tx),
        .o_tx_done    (o_tx_done),
        .o_frame_error(o_frame_error)
    );

    always #5 i_clock = ~i_clock;

    //////////////////////////////////////////////////
    // Failure reporting and checks.
    //////////////////////////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error: %s is 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Serial driver and monitor.
    //////////////////////////////////////////////////

    // Holds one bit on i_rx for a full bit period.
    task automatic send_bit(input logic value, input logic quiet);
        @(posedge i_clock);
        i_rx <= value;
        @(negedge i_clock);
        if (quiet) begin
            check_value("o_tx", 8'(o_tx), 8'h01);
        end
        repeat (BIT_CYCLES - 1) @(posedge i_clock);
    endtask

    // Start bit, data MSB first, then stop bits.
    task automatic send_byte(input logic [7:0] data, input logic bad_stop,
                             input logic quiet);
        send_bit(1'b0, quiet);
        for (int i = 7; i >= 0; i--) begin
            send_bit(data[i], quiet);
        end
        for (int s = 0; s < STOP_BITS; s++) begin
            send_bit(!(bad_stop && (s == 0)), quiet);
        end
    endtask

    task automatic receive_reply(output logic [7:0] data);
        int waited;
        waited = 0;
        while (o_tx !== 1'b0) begin
            @(negedge i_clock);
            waited++;
            if (waited > REPLY_TIMEOUT) begin
                stop_with_failure("no reply frame started on o_tx");
            end
        end
        // Mid start bit.
        repeat (BIT_CYCLES / 2) @(negedge i_clock);
        if (o_tx !== 1'b0) begin
            stop_with_failure("reply start bit is high at mid-bit");
        end
        check_value("o_tx_done", 8'(o_tx_done), 8'h00);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge i_clock);
            data = {data[6:0], o_tx};
            check_value("o_tx_done", 8'(o_tx_done), 8'h00);
        end
        for (int s = 0; s < STOP_BITS; s++) begin
            repeat (BIT_CYCLES) @(negedge i_clock);
            if (o_tx !== 1'b1) begin
                stop_with_failure("reply stop bit is low at mid-bit");
            end
            check_value("o_tx_done", 8'(o_tx_done), 8'h00);
        end
        waited = 0;
        while (o_tx_done !== 1'b1) begin
            @(negedge i_clock);
            waited++;
            if (waited > BIT_CYCLES) begin
                stop_with_failure("o_tx_done did not rise after the reply stop bits");
            end
        end
    endtask

    task automatic wait_frame_error();
        int waited;
        waited = 0;
        while (o_frame_error !== 1'b1) begin
            @(negedge i_clock);
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                stop_with_failure("o_frame_error did not pulse for a bad stop bit");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table.
    //////////////////////////////////////////////////

    function automatic test_row_t make_row(input logic [7:0] a, input logic [7:0] b,
                                           input logic [7:0] op, input logic [7:0] expected,
                                           input logic bad_stop);
        test_row_t row;
        row.operand_a = a;
        row.operand_b = b;
        row.opcode    = op;
        row.expected  = expected;
        row.bad_stop  = bad_stop;
        return row;
    endfunction

    task automatic fill_table();
        logic [7:0] a [4];
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++) begin
            a[i] = 8'($urandom());
            b[i] = 8'($urandom());
        end
        // Wraparound cases.
        rows[0]  = make_row(8'hF0, 8'h20, 8'(uart_alu_pkg::ADD), 8'h10, 1'b0);
        rows[1]  = make_row(8'h05, 8'h07, 8'(uart_alu_pkg::SUB), 8'hFE, 1'b0);
        rows[2]  = make_row(8'h7F, 8'h01, 8'(uart_alu_pkg::ADD), 8'h80, 1'b0);
        rows[3]  = make_row(a[0], b[0], 8'(uart_alu_pkg::AND), a[0] & b[0], 1'b0);
        rows[4]  = make_row(a[1], b[1], 8'(uart_alu_pkg::OR), a[1] | b[1], 1'b0);
        rows[5]  = make_row(a[2], b[2], 8'(uart_alu_pkg::XOR), a[2] ^ b[2], 1'b0);
        rows[6]  = make_row(a[3], b[3], 8'(uart_alu_pkg::NOR), ~(a[3] | b[3]), 1'b0);
        rows[7]  = make_row(8'h96, 8'h03, 8'(uart_alu_pkg::SRL), 8'h12, 1'b0);
        rows[8]  = make_row(8'h96, 8'h03, 8'(uart_alu_pkg::SRA), 8'hF2, 1'b0);
        rows[9]  = make_row(8'h5A, 8'hA5, 8'h3F, 8'h00, 1'b0);
        // Operand A goes out once with a low stop bit first.
        rows[10] = make_row(8'h12, 8'h34, 8'(uart_alu_pkg::ADD), 8'h46, 1'b1);
    endtask

    initial begin
        test_row_t  row;
        logic [7:0] reply;
        i_clock = 1'b0;
        i_reset = 1'b0;
        i_rx    = 1'b1;
        void'($urandom(7));
        fill_table();
        repeat (3) @(posedge i_clock);
        i_reset <= 1'b1;

        // Quiet outputs after reset.
        repeat (IDLE_CYCLES) begin
            @(negedge i_clock);
            check_value("o_tx", 8'(o_tx), 8'h01);
            check_value("o_tx_done", 8'(o_tx_done), 8'h01);
            check_value("o_frame_error", 8'(o_frame_error), 8'h00);
        end

        for (int r = 0; r < ROW_COUNT; r++) begin
            row = rows[r];
            if (row.bad_stop) begin
                fork
                    send_byte(row.operand_a, 1'b1, 1'b1);
                    wait_frame_error();
                join
            end
            send_byte(row.operand_a, 1'b0, 1'b1);
            send_byte(row.operand_b, 1'b0, 1'b1);
            fork
                send_byte(row.opcode, 1'b0, 1'b0);
                receive_reply(reply);
            join
            check_value($sformatf("o_tx reply byte, row %0d", r), reply, row.expected);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
